// File: threshold_reset_top.f
logic/threshold_reset_pkg.sv
logic/axil_slave_port.sv
logic/threshold_monitor.sv
logic/threshold_reset_top.sv
sim/threshold_reset_sva.sv
sim/tb_threshold_reset_top.sv

// File: Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert -Wall
TOP        ?= tb_threshold_reset_top
FILELIST   ?= threshold_reset_top.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := TEST PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: sim/tb_threshold_reset_top.sv
// Threshold reset generator testbench
module tb_threshold_reset_top;

    localparam int SIGNAL_WIDTH = 8;
    localparam int ADDR_WIDTH   = 32;
    localparam int CLK_PERIOD   = 40;
    localparam int RESP_LIMIT   = 16;

    // Transactions per phase
    localparam int N_RW   = 8;
    localparam int N_CMP  = 16;
    localparam int N_HOLD = 4;
    localparam int N_BP   = 8;
    localparam int N_TRANSACTIONS = 14 + 6 * N_RW + 3 * N_CMP + 3 * N_HOLD + 2 * N_BP;
    // Worst case of 20 cycles per transaction plus reset and margin
    localparam int TIMEOUT = (N_TRANSACTIONS * 20 + 50) * CLK_PERIOD;

    logic                  s_axi_aclk;
    logic                  s_axi_aresetn;
    logic [ADDR_WIDTH-1:0] s_axi_awaddr;
    logic                  s_axi_awvalid;
    logic                  s_axi_awready;
    logic [31:0]           s_axi_wdata;
    logic [3:0]            s_axi_wstrb;
    logic                  s_axi_wvalid;
    logic                  s_axi_wready;
    logic [1:0]            s_axi_bresp;
    logic                  s_axi_bvalid;
    logic                  s_axi_bready;
    logic [ADDR_WIDTH-1:0] s_axi_araddr;
    logic                  s_axi_arvalid;
    logic                  s_axi_arready;
    logic [31:0]           s_axi_rdata;
    logic [1:0]            s_axi_rresp;
    logic                  s_axi_rvalid;
    logic                  s_axi_rready;
    logic                  reset_out;

    int seed;
    int check_count;
    int value_errors;
    int other_errors;

    // Shadow copy of the register file
    logic [SIGNAL_WIDTH-1:0] sh_signal;
    logic [SIGNAL_WIDTH-1:0] sh_threshold;
    logic [2:0]              sh_control;
    logic                    sh_reset;

    // Comparisons waiting for the checker
    string       name_q[$];
    logic [31:0] exp_q[$];
    logic [31:0] act_q[$];

    threshold_reset_top #(
        .SIGNAL_WIDTH (SIGNAL_WIDTH),
        .ADDR_WIDTH   (ADDR_WIDTH)
    ) u_dut (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .reset_out     (reset_out)
    );

    always #(CLK_PERIOD / 2) s_axi_aclk = ~s_axi_aclk;

    // Expected read data from the register map rules
    function automatic logic [31:0] model_read(
        input logic [3:0]              offset,
        input logic [SIGNAL_WIDTH-1:0] sig,
        input logic [SIGNAL_WIDTH-1:0] thr,
        input logic [2:0]              ctrl,
        input logic                    rst
    );
        logic [31:0] value;
        value = 32'd0;
        case (offset)
            threshold_reset_pkg::OFF_SIGNAL_VALUE: value[SIGNAL_WIDTH-1:0] = sig;
            threshold_reset_pkg::OFF_THRESHOLD:    value[SIGNAL_WIDTH-1:0] = thr;
            threshold_reset_pkg::OFF_STATUS: begin
                value[2:0] = ctrl;
                value[threshold_reset_pkg::STATUS_RESET_BIT] = rst;
            end
            default: value = 32'd0;
        endcase
        return value;
    endfunction

    task automatic update_shadow(input logic [3:0] offset, input logic [31:0] data,
                                 input logic strb0);
        if (strb0) begin
            case (offset)
                threshold_reset_pkg::OFF_SIGNAL_VALUE: sh_signal = data[SIGNAL_WIDTH-1:0];
                threshold_reset_pkg::OFF_THRESHOLD:    sh_threshold = data[SIGNAL_WIDTH-1:0];
                threshold_reset_pkg::OFF_STATUS:       sh_control = data[2:0];
                default: begin
                end
            endcase
        end
        // Enabled monitor follows the comparison
        if (sh_control[0]) begin
            sh_reset = sh_signal > sh_threshold;
        end
    endtask

    task automatic expect_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        name_q.push_back(name);
        exp_q.push_back(expected);
        act_q.push_back(actual);
    endtask

    task automatic axil_write(input logic [3:0] offset, input logic [31:0] data,
                              input logic [3:0] strb, input int stall);
        int cycles;
        @(posedge s_axi_aclk);
        s_axi_awaddr  <= ADDR_WIDTH'(offset);
        s_axi_awvalid <= 1'b1;
        s_axi_wdata   <= data;
        s_axi_wstrb   <= strb;
        s_axi_wvalid  <= 1'b1;
        cycles = 0;
        do begin
            @(posedge s_axi_aclk);
            cycles++;
        end while (!(s_axi_awready && s_axi_wready) && cycles < RESP_LIMIT);
        s_axi_awvalid <= 1'b0;
        s_axi_wvalid  <= 1'b0;
        assert (s_axi_awready && s_axi_wready) else begin
            other_errors++;
            $display("Write to offset %h was never accepted", offset);
        end
        if (!(s_axi_awready && s_axi_wready)) begin
            return;
        end
        cycles = 0;
        do begin
            @(posedge s_axi_aclk);
            cycles++;
        end while (!s_axi_bvalid && cycles < RESP_LIMIT);
        assert (s_axi_bvalid) else begin
            other_errors++;
            $display("Write to offset %h got no response", offset);
        end
        if (!s_axi_bvalid) begin
            return;
        end
        // Response must wait while bready is low
        repeat (stall) begin
            @(posedge s_axi_aclk);
            assert (s_axi_bvalid) else begin
                other_errors++;
                $display("bvalid dropped while bready was low");
            end
        end
        s_axi_bready <= 1'b1;
        @(posedge s_axi_aclk);
        s_axi_bready <= 1'b0;
        expect_value("bresp", 32'(threshold_reset_pkg::AXI_RESP_OKAY), 32'(s_axi_bresp));
    endtask

    task automatic axil_read(input logic [3:0] offset, input int stall,
                             output logic [31:0] data);
        int cycles;
        logic [31:0] first;
        data = 'x;
        @(posedge s_axi_aclk);
        s_axi_araddr  <= ADDR_WIDTH'(offset);
        s_axi_arvalid <= 1'b1;
        cycles = 0;
        do begin
            @(posedge s_axi_aclk);
            cycles++;
        end while (!s_axi_arready && cycles < RESP_LIMIT);
        s_axi_arvalid <= 1'b0;
        assert (s_axi_arready) else begin
            other_errors++;
            $display("Read of offset %h was never accepted", offset);
        end
        if (!s_axi_arready) begin
            return;
        end
        cycles = 0;
        do begin
            @(posedge s_axi_aclk);
            cycles++;
        end while (!s_axi_rvalid && cycles < RESP_LIMIT);
        assert (s_axi_rvalid) else begin
            other_errors++;
            $display("Read of offset %h got no data", offset);
        end
        if (!s_axi_rvalid) begin
            return;
        end
        first = s_axi_rdata;
        repeat (stall) begin
            @(posedge s_axi_aclk);
            assert (s_axi_rvalid && s_axi_rdata === first) else begin
                other_errors++;
                $display("Read data changed or rvalid dropped while rready was low");
            end
        end
        s_axi_rready <= 1'b1;
        @(posedge s_axi_aclk);
        s_axi_rready <= 1'b0;
        data = s_axi_rdata;
        expect_value("rresp", 32'(threshold_reset_pkg::AXI_RESP_OKAY), 32'(s_axi_rresp));
    endtask

    task automatic do_write(input string name, input logic [3:0] offset,
                            input logic [31:0] data, input logic [3:0] strb, input int stall);
        axil_write(offset, data, strb, stall);
        update_shadow(offset, data, strb[0]);
        expect_value({name, " reset_out"}, {31'd0, sh_reset}, {31'd0, reset_out});
    endtask

    task automatic check_read(input string name, input logic [3:0] offset, input int stall);
        logic [31:0] data;
        axil_read(offset, stall, data);
        expect_value(name, model_read(offset, sh_signal, sh_threshold, sh_control, sh_reset),
                     data);
    endtask

    // Checker drains the queue between clock edges
    always @(negedge s_axi_aclk) begin
        string       name;
        logic [31:0] exp_val;
        logic [31:0] act_val;
        while (exp_q.size() > 0) begin
            name    = name_q.pop_front();
            exp_val = exp_q.pop_front();
            act_val = act_q.pop_front();
            check_count++;
            assert (act_val === exp_val) else begin
                value_errors++;
                $display("Error: %s expected %h actual %h", name, exp_val, act_val);
            end
        end
    end

    // Watchdog
    initial begin
        #(TIMEOUT);
        $display("Timeout: run did not finish within %0d time units", TIMEOUT);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int          i;
        int          stall;
        logic [31:0] value;
        logic [31:0] other;
        logic [3:0]  offset;
        seed = 46298;
        check_count = 0;
        value_errors = 0;
        other_errors = 0;
        sh_signal = '0;
        sh_threshold = '0;
        sh_control = '0;
        sh_reset = 1'b0;
        s_axi_aclk = 1'b0;
        s_axi_aresetn = 1'b0;
        s_axi_awaddr = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata = '0;
        s_axi_wstrb = '0;
        s_axi_wvalid = 1'b0;
        s_axi_bready = 1'b0;
        s_axi_araddr = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready = 1'b0;
        repeat (2) @(posedge s_axi_aclk);
        s_axi_aresetn <= 1'b1;

        // Reset values
        expect_value("reset_out after reset", 32'd0, {31'd0, reset_out});
        check_read("reset SIGNAL_VALUE", threshold_reset_pkg::OFF_SIGNAL_VALUE, 0);
        check_read("reset THRESHOLD", threshold_reset_pkg::OFF_THRESHOLD, 0);
        check_read("reset STATUS", threshold_reset_pkg::OFF_STATUS, 0);

        // Write and readback
        for (i = 0; i < N_RW; i++) begin
            value = $random(seed);
            do_write("rw SIGNAL_VALUE", threshold_reset_pkg::OFF_SIGNAL_VALUE, value, 4'hf, 0);
            value = $random(seed);
            do_write("rw THRESHOLD", threshold_reset_pkg::OFF_THRESHOLD, value, 4'hf, 0);
            value = $random(seed);
            do_write("rw STATUS", threshold_reset_pkg::OFF_STATUS, value, 4'hf, 0);
            check_read("rw SIGNAL_VALUE", threshold_reset_pkg::OFF_SIGNAL_VALUE, 0);
            check_read("rw THRESHOLD", threshold_reset_pkg::OFF_THRESHOLD, 0);
            check_read("rw STATUS", threshold_reset_pkg::OFF_STATUS, 0);
        end

        // Strobe lane 0 low and then an unmapped offset
        value = {24'd0, ~sh_threshold};
        do_write("strobe low", threshold_reset_pkg::OFF_THRESHOLD, value, 4'he, 0);
        check_read("strobe low THRESHOLD", threshold_reset_pkg::OFF_THRESHOLD, 0);
        do_write("unmapped", 4'hc, $random(seed), 4'hf, 0);
        check_read("unmapped read", 4'hc, 0);
        check_read("decode SIGNAL_VALUE", threshold_reset_pkg::OFF_SIGNAL_VALUE, 0);
        check_read("decode THRESHOLD", threshold_reset_pkg::OFF_THRESHOLD, 0);
        check_read("decode STATUS", threshold_reset_pkg::OFF_STATUS, 0);

        // Comparison with updates enabled and every fourth pair equal
        do_write("enable", threshold_reset_pkg::OFF_STATUS, 32'h1, 4'h1, 0);
        for (i = 0; i < N_CMP; i++) begin
            value = $random(seed);
            if (i % 4 == 0) begin
                other = value;
            end else begin
                other = $random(seed);
            end
            do_write("cmp SIGNAL_VALUE", threshold_reset_pkg::OFF_SIGNAL_VALUE, value, 4'h1, 0);
            do_write("cmp THRESHOLD", threshold_reset_pkg::OFF_THRESHOLD, other, 4'h1, 0);
            check_read("cmp STATUS", threshold_reset_pkg::OFF_STATUS, 0);
        end

        // Hold while disabled with values that flip the comparison
        do_write("disable", threshold_reset_pkg::OFF_STATUS, 32'h0, 4'h1, 0);
        for (i = 0; i < N_HOLD; i++) begin
            if (sh_reset) begin
                value = 32'd0;
                other = $random(seed) | 32'd1;
            end else begin
                value = $random(seed) | 32'd1;
                other = 32'd0;
            end
            do_write("hold SIGNAL_VALUE", threshold_reset_pkg::OFF_SIGNAL_VALUE, value, 4'h1, 0);
            do_write("hold THRESHOLD", threshold_reset_pkg::OFF_THRESHOLD, other, 4'h1, 0);
            check_read("hold STATUS", threshold_reset_pkg::OFF_STATUS, 0);
        end
        do_write("re-enable", threshold_reset_pkg::OFF_STATUS, 32'h1, 4'h1, 0);
        check_read("re-enable STATUS", threshold_reset_pkg::OFF_STATUS, 0);

        // Back-pressure on both response channels
        for (i = 0; i < N_BP; i++) begin
            offset = (i % 2 == 0) ? threshold_reset_pkg::OFF_SIGNAL_VALUE :
                                    threshold_reset_pkg::OFF_THRESHOLD;
            value = $random(seed);
            stall = 1 + int'($unsigned($random(seed)) % 32'd7);
            do_write("stalled write", offset, value, 4'hf, stall);
            stall = 1 + int'($unsigned($random(seed)) % 32'd7);
            check_read("stalled read", offset, stall);
        end

        repeat (2) @(posedge s_axi_aclk);
        $display("Summary: %0d checks, %0d value errors, %0d other errors",
                 check_count, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: sim/threshold_reset_sva.sv
// AXI4-Lite slave port protocol checks
module threshold_reset_sva (
    input logic                             s_axi_aclk,
    input logic                             s_axi_aresetn,
    input logic                             s_axi_awready,
    input logic                             s_axi_wready,
    input logic [1:0]                       s_axi_bresp,
    input logic                             s_axi_bvalid,
    input logic                             s_axi_bready,
    input logic                             s_axi_arready,
    input logic [31:0]                      s_axi_rdata,
    input logic [1:0]                       s_axi_rresp,
    input logic                             s_axi_rvalid,
    input logic                             s_axi_rready,
    input threshold_reset_pkg::axil_state_e wr_state,
    input threshold_reset_pkg::axil_state_e rd_state
);

    a_bvalid_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
        else $error("bvalid dropped before bready");

    // Read data frozen until the master takes it
    a_rvalid_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata))
        else $error("rvalid or rdata changed while rready was low");

    a_ready_pair: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_awready == s_axi_wready)
        else $error("awready and wready differ");

    a_resp_okay: assert property (@(posedge s_axi_aclk)
        s_axi_bresp == threshold_reset_pkg::AXI_RESP_OKAY &&
        s_axi_rresp == threshold_reset_pkg::AXI_RESP_OKAY)
        else $error("response code is not OKAY");

    a_reset_quiet: assert property (@(posedge s_axi_aclk)
        !s_axi_aresetn |=> !s_axi_awready && !s_axi_wready && !s_axi_arready)
        else $error("ready output high during reset");

    a_bvalid_state: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_bvalid |-> wr_state == threshold_reset_pkg::ST_RESP)
        else $error("bvalid outside the write response state");

    a_rvalid_state: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_rvalid |-> rd_state == threshold_reset_pkg::ST_RESP)
        else $error("rvalid outside the read response state");

endmodule

bind axil_slave_port threshold_reset_sva u_sva (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .s_axi_awready (s_axi_awready),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .wr_state      (wr_state),
    .rd_state      (rd_state)
);

// File: logic/threshold_reset_top.sv
// Threshold reset generator top level
module threshold_reset_top #(
    parameter int SIGNAL_WIDTH = 8,
    parameter int ADDR_WIDTH   = 32
) (
    input  logic                  s_axi_aclk,
    input  logic                  s_axi_aresetn,

    input  logic [ADDR_WIDTH-1:0] s_axi_awaddr,
    input  logic                  s_axi_awvalid,
    output logic                  s_axi_awready,

    input  logic [31:0]           s_axi_wdata,
    input  logic [3:0]            s_axi_wstrb,
    input  logic                  s_axi_wvalid,
    output logic                  s_axi_wready,

    output logic [1:0]            s_axi_bresp,
    output logic                  s_axi_bvalid,
    input  logic                  s_axi_bready,

    input  logic [ADDR_WIDTH-1:0] s_axi_araddr,
    input  logic                  s_axi_arvalid,
    output logic                  s_axi_arready,

    output logic [31:0]           s_axi_rdata,
    output logic [1:0]            s_axi_rresp,
    output logic                  s_axi_rvalid,
    input  logic                  s_axi_rready,

    output logic                  reset_out
);

    // Between bus port and register file
    threshold_reset_pkg::reg_wr_t wr_req;
    logic [3:0]                   rd_offset;
    logic [31:0]                  rd_data;

    axil_slave_port #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_port (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .wr_req        (wr_req),
        .rd_offset     (rd_offset),
        .rd_data       (rd_data)
    );

    threshold_monitor #(
        .SIGNAL_WIDTH (SIGNAL_WIDTH)
    ) u_monitor (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .wr_req        (wr_req),
        .rd_offset     (rd_offset),
        .rd_data       (rd_data),
        .reset_out     (reset_out)
    );

endmodule

// File: logic/threshold_monitor.sv
// Threshold register file and comparator
module threshold_monitor #(
    parameter int SIGNAL_WIDTH = 8
) (
    input  logic                          s_axi_aclk,
    input  logic                          s_axi_aresetn,
    input  threshold_reset_pkg::reg_wr_t  wr_req,
    input  logic [3:0]                    rd_offset,
    output logic [31:0]                   rd_data,
    output logic                          reset_out
);

    logic [SIGNAL_WIDTH-1:0] signal_value;
    logic [SIGNAL_WIDTH-1:0] threshold;
    logic [2:0]              control;
    logic                    exceeded;
    logic [31:0]             status_word;

    // Register writes, lane 0 only
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            signal_value <= '0;
            threshold    <= '0;
            control      <= '0;
        end else if (wr_req.en && wr_req.strb0) begin
            case (wr_req.offset)
                threshold_reset_pkg::OFF_SIGNAL_VALUE: begin
                    signal_value <= wr_req.data[SIGNAL_WIDTH-1:0];
                end
                threshold_reset_pkg::OFF_THRESHOLD: begin
                    threshold <= wr_req.data[SIGNAL_WIDTH-1:0];
                end
                threshold_reset_pkg::OFF_STATUS: begin
                    control <= wr_req.data[2:0];
                end
                default: begin
                    // Unmapped offset, write dropped
                end
            endcase
        end
    end

    // Strictly greater, equal values do not trip the reset
    assign exceeded = signal_value > threshold;

    // Control bit 0 enables updates, otherwise hold
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            reset_out <= 1'b0;
        end else if (control[0]) begin
            reset_out <= exceeded;
        end
    end

    // STATUS layout: control in [2:0], reset_out readback above
    always_comb begin
        status_word = '0;
        status_word[2:0] = control;
        status_word[threshold_reset_pkg::STATUS_RESET_BIT] = reset_out;
    end

    // Read mux
    always_comb begin
        case (rd_offset)
            threshold_reset_pkg::OFF_SIGNAL_VALUE: rd_data = 32'(signal_value);
            threshold_reset_pkg::OFF_THRESHOLD:    rd_data = 32'(threshold);
            threshold_reset_pkg::OFF_STATUS:       rd_data = status_word;
            default:                               rd_data = '0;
        endcase
    end

endmodule

// File: logic/axil_slave_port.sv
// AXI4-Lite slave port
module axil_slave_port #(
    parameter int ADDR_WIDTH = 32
) (
    input  logic                          s_axi_aclk,
    input  logic                          s_axi_aresetn,

    // Write address channel
    input  logic [ADDR_WIDTH-1:0]         s_axi_awaddr,
    input  logic                          s_axi_awvalid,
    output logic                          s_axi_awready,

    // Write data channel
    input  logic [31:0]                   s_axi_wdata,
    input  logic [3:0]                    s_axi_wstrb,
    input  logic                          s_axi_wvalid,
    output logic                          s_axi_wready,

    // Write response channel
    output logic [1:0]                    s_axi_bresp,
    output logic                          s_axi_bvalid,
    input  logic                          s_axi_bready,

    // Read address channel
    input  logic [ADDR_WIDTH-1:0]         s_axi_araddr,
    input  logic                          s_axi_arvalid,
    output logic                          s_axi_arready,

    // Read data channel
    output logic [31:0]                   s_axi_rdata,
    output logic [1:0]                    s_axi_rresp,
    output logic                          s_axi_rvalid,
    input  logic                          s_axi_rready,

    // Register file side
    output threshold_reset_pkg::reg_wr_t  wr_req,
    output logic [3:0]                    rd_offset,
    input  logic [31:0]                   rd_data
);

    threshold_reset_pkg::axil_state_e wr_state;
    threshold_reset_pkg::axil_state_e rd_state;

    logic        wr_accept;
    logic        wr_en;
    logic [3:0]  wr_offset;
    logic [31:0] wr_data;
    logic        wr_strb0;

    // Address and data must arrive together before a write starts
    assign wr_accept = (wr_state == threshold_reset_pkg::ST_IDLE) &&
                       s_axi_awvalid && s_axi_wvalid;

    assign wr_req = '{
        en:     wr_en,
        offset: wr_offset,
        data:   wr_data,
        strb0:  wr_strb0
    };

    // No error responses are ever generated
    assign s_axi_bresp = threshold_reset_pkg::AXI_RESP_OKAY;
    assign s_axi_rresp = threshold_reset_pkg::AXI_RESP_OKAY;

    // Write FSM
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            wr_state      <= threshold_reset_pkg::ST_IDLE;
            s_axi_awready <= 1'b0;
            s_axi_wready  <= 1'b0;
            s_axi_bvalid  <= 1'b0;
            wr_en         <= 1'b0;
        end else begin
            case (wr_state)
                threshold_reset_pkg::ST_IDLE: begin
                    if (wr_accept) begin
                        s_axi_awready <= 1'b1;
                        s_axi_wready  <= 1'b1;
                        wr_en         <= 1'b1;
                        wr_state      <= threshold_reset_pkg::ST_ACCESS;
                    end
                end
                threshold_reset_pkg::ST_ACCESS: begin
                    // Register file updates at the end of this cycle
                    s_axi_awready <= 1'b0;
                    s_axi_wready  <= 1'b0;
                    wr_en         <= 1'b0;
                    s_axi_bvalid  <= 1'b1;
                    wr_state      <= threshold_reset_pkg::ST_RESP;
                end
                threshold_reset_pkg::ST_RESP: begin
                    if (s_axi_bready) begin
                        s_axi_bvalid <= 1'b0;
                        wr_state     <= threshold_reset_pkg::ST_IDLE;
                    end
                end
                default: begin
                    wr_state <= threshold_reset_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // Write payload captured on the accepting edge
    always_ff @(posedge s_axi_aclk) begin
        if (wr_accept) begin
            wr_offset <= s_axi_awaddr[3:0];
            wr_data   <= s_axi_wdata;
            wr_strb0  <= s_axi_wstrb[0];
        end
    end

    // Read FSM
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            rd_state      <= threshold_reset_pkg::ST_IDLE;
            s_axi_arready <= 1'b0;
            s_axi_rvalid  <= 1'b0;
        end else begin
            case (rd_state)
                threshold_reset_pkg::ST_IDLE: begin
                    if (s_axi_arvalid) begin
                        s_axi_arready <= 1'b1;
                        rd_state      <= threshold_reset_pkg::ST_ACCESS;
                    end
                end
                threshold_reset_pkg::ST_ACCESS: begin
                    s_axi_arready <= 1'b0;
                    s_axi_rvalid  <= 1'b1;
                    rd_state      <= threshold_reset_pkg::ST_RESP;
                end
                threshold_reset_pkg::ST_RESP: begin
                    // Hold rvalid and rdata until the master takes them
                    if (s_axi_rready) begin
                        s_axi_rvalid <= 1'b0;
                        rd_state     <= threshold_reset_pkg::ST_IDLE;
                    end
                end
                default: begin
                    rd_state <= threshold_reset_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // Read address and data path
    always_ff @(posedge s_axi_aclk) begin
        if (rd_state == threshold_reset_pkg::ST_IDLE && s_axi_arvalid) begin
            rd_offset <= s_axi_araddr[3:0];
        end
        if (rd_state == threshold_reset_pkg::ST_ACCESS) begin
            s_axi_rdata <= rd_data;
        end
    end

endmodule

// File: logic/threshold_reset_pkg.sv
// Threshold reset shared definitions
package threshold_reset_pkg;

    // Register map, only the low 4 address bits are decoded
    typedef enum logic [3:0] {
        OFF_SIGNAL_VALUE = 4'h0,
        OFF_THRESHOLD    = 4'h4,
        OFF_STATUS       = 4'h8
    } reg_offset_e;

    // Shared by the write and read channel FSMs
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_ACCESS = 2'd1,
        ST_RESP   = 2'd2
    } axil_state_e;

    // Write request from the bus side to the register file
    typedef struct packed {
        logic        en;
        logic [3:0]  offset;
        logic [31:0] data;
        logic        strb0;
    } reg_wr_t;

    // AXI response code
    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    // Position of the reset_out readback in STATUS
    localparam int STATUS_RESET_BIT = 4;

endpackage
